//--- verilog/udp_rx_pkg.sv
`default_nettype none

package udp_rx_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [15:0] len_t;
  typedef logic [15:0] cnt_t;

  localparam len_t       IPV4_HDR_LEN = 16'd20;
  localparam len_t       UDP_HDR_LEN  = 16'd8;
  localparam byte_t      PROTO_UDP    = 8'd17;
  localparam logic [3:0] IPV4_VERSION = 4'd4;
  localparam logic [3:0] IPV4_IHL     = 4'd5; // No options

  // Byte stream with plain strobes
  typedef struct packed {
    byte_t dat;
    logic  val;
    logic  sof;
    logic  eof;
    logic  err; // Only together with eof
  } strm_t;

  typedef struct packed {
    byte_t      proto;
    len_t       total_len;
    ipv4_addr_t src_ip;
    ipv4_addr_t dst_ip;
    logic [15:0] id;
    byte_t      ttl;
  } ipv4_hdr_t;

  typedef struct packed {
    udp_port_t   src_port;
    udp_port_t   dst_port;
    len_t        length;
    logic [15:0] cks;
  } udp_hdr_t;

  typedef struct packed {
    ipv4_hdr_t ipv4_hdr;
    len_t      pld_len; // total_len less the IPv4 header
  } ipv4_meta_t;

  typedef struct packed {
    ipv4_hdr_t ipv4_hdr;
    udp_hdr_t  udp_hdr;
  } udp_meta_t;

  // Own address and port of the device
  typedef struct packed {
    ipv4_addr_t ipv4_addr;
    udp_port_t  udp_port;
  } dev_t;

endpackage

`default_nettype wire

//--- verilog/ipv4_rx.sv
`timescale 1ns/100ps
`default_nettype none

module ipv4_rx
  import udp_rx_pkg::*;
(
  input  logic       clk,
  input  logic       fsm_rst,
  input  dev_t       dev,
  input  strm_t      rx,
  output strm_t      ip_strm,
  output ipv4_meta_t ip_meta
);

  typedef enum logic [1:0] {ST_IDLE, ST_HDR, ST_PLD, ST_DISC} state_t;

  state_t state;
  len_t   hdr_cnt;
  len_t   rem;      // Payload bytes still expected
  byte_t [IPV4_HDR_LEN-1:0] hdr;
  logic [19:0] cks_acc;
  logic   first;
  logic   ovr;
  logic   frm_clr;

  byte_t [IPV4_HDR_LEN-1:0] hdr_full;
  ipv4_hdr_t   hdr_new;
  len_t        pld_len;
  logic [15:0] cks_word;
  logic [19:0] cks_sum;
  logic [16:0] cks_fold1;
  logic [15:0] cks_fold2;
  logic hdr_take;
  logic hdr_last;
  logic hdr_ok;
  logic pld_take;
  logic frm_end;
  len_t rem_nxt;

  // Nothing is taken in the clear cycle
  assign hdr_take = !frm_clr && rx.val && ((state == ST_IDLE && rx.sof) || state == ST_HDR);
  assign hdr_last = hdr_take && hdr_cnt == IPV4_HDR_LEN - 16'd1;
  assign hdr_full = {hdr[IPV4_HDR_LEN-2:0], rx.dat}; // Byte 0 ends up on top

  always_comb begin
    hdr_new.proto     = hdr_full[10];
    hdr_new.total_len = {hdr_full[17], hdr_full[16]};
    hdr_new.src_ip    = hdr_full[7:4];
    hdr_new.dst_ip    = hdr_full[3:0];
    hdr_new.id        = {hdr_full[15], hdr_full[14]};
    hdr_new.ttl       = hdr_full[11];
  end

  assign pld_len = hdr_new.total_len - IPV4_HDR_LEN;

  // Ones-complement sum, one word per odd byte
  assign cks_word  = {hdr[0], rx.dat};
  assign cks_sum   = cks_acc + {4'd0, cks_word};
  assign cks_fold1 = {1'b0, cks_sum[15:0]} + {13'd0, cks_sum[19:16]};
  assign cks_fold2 = cks_fold1[15:0] + {15'd0, cks_fold1[16]};

  assign hdr_ok = hdr_full[19][7:4] == IPV4_VERSION &&
                  hdr_full[19][3:0] == IPV4_IHL &&
                  cks_fold2 == 16'hffff &&
                  hdr_new.dst_ip == dev.ipv4_addr &&
                  hdr_new.total_len > IPV4_HDR_LEN;

  assign pld_take = rx.val && state == ST_PLD && rem != '0;
  assign rem_nxt  = pld_take ? rem - 16'd1 : rem;
  assign frm_end  = rx.eof && (state != ST_IDLE || hdr_take);

  always_ff @(posedge clk) begin
    if (fsm_rst || frm_clr) begin
      state   <= ST_IDLE;
      hdr_cnt <= '0;
      cks_acc <= '0;
      rem     <= '0;
      first   <= 1'b0;
      ovr     <= 1'b0;
    end else begin
      if (hdr_take) begin
        hdr_cnt <= hdr_cnt + 16'd1;
        if (hdr_cnt[0]) cks_acc <= cks_sum;
      end
      if (pld_take) begin
        rem   <= rem_nxt;
        first <= 1'b0;
      end
      if (state == ST_PLD && rx.val && rem == '0) ovr <= 1'b1; // Bytes past total_len
      case (state)
        ST_IDLE: if (hdr_take && !rx.eof) state <= ST_HDR;
        ST_HDR: begin
          if (rx.eof) begin
            state <= ST_IDLE;
          end else if (hdr_last) begin
            state <= hdr_ok ? ST_PLD : ST_DISC;
            rem   <= pld_len;
            first <= 1'b1;
          end
        end
        ST_PLD:  if (rx.eof) state <= ST_IDLE;
        ST_DISC: if (rx.eof) state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) frm_clr <= 1'b0;
    else frm_clr <= frm_end;
  end

  always_ff @(posedge clk) begin
    if (hdr_take) hdr <= hdr_full;
    if (hdr_last && hdr_ok) begin
      ip_meta.ipv4_hdr <= hdr_new;
      ip_meta.pld_len  <= pld_len;
    end
  end

  always_ff @(posedge clk) begin
    ip_strm.dat <= rx.dat;
    if (fsm_rst) begin
      ip_strm.val <= 1'b0;
      ip_strm.sof <= 1'b0;
      ip_strm.eof <= 1'b0;
      ip_strm.err <= 1'b0;
    end else begin
      ip_strm.val <= pld_take;
      ip_strm.sof <= pld_take && first;
      ip_strm.eof <= state == ST_PLD && rx.eof;
      // Short frame, overrun or upstream error
      ip_strm.err <= state == ST_PLD && rx.eof &&
                     (rx.err || ovr || rem_nxt != '0 || (rx.val && rem == '0));
    end
  end

endmodule

`default_nettype wire

//--- verilog/udp_rx.sv
`timescale 1ns/100ps
`default_nettype none

module udp_rx
  import udp_rx_pkg::*;
(
  input  logic       clk,
  input  logic       fsm_rst,
  input  strm_t      ip_strm,
  input  ipv4_meta_t ip_meta,
  output strm_t      udp_strm,
  output udp_meta_t  udp_meta
);

  byte_t [UDP_HDR_LEN-1:0] hdr;
  byte_t [UDP_HDR_LEN-1:0] hdr_full;
  len_t byte_cnt;
  len_t cnt_nxt;
  logic receiving;
  logic hdr_done;
  logic frm_clr;
  logic start;
  logic in_frm;
  logic take;
  logic len_err;

  // Only UDP frames open a datagram
  assign start    = !frm_clr && ip_strm.sof && ip_meta.ipv4_hdr.proto == PROTO_UDP;
  assign in_frm   = receiving || start;
  assign take     = in_frm && ip_strm.val;
  assign cnt_nxt  = take ? byte_cnt + 16'd1 : byte_cnt;
  assign hdr_full = {hdr[UDP_HDR_LEN-2:0], ip_strm.dat};

  // Byte count and UDP length must both agree with the IPv4 payload length
  assign len_err = cnt_nxt != ip_meta.pld_len ||
                   udp_meta.udp_hdr.length != ip_meta.pld_len;

  always_ff @(posedge clk) begin
    if (fsm_rst || frm_clr) begin
      receiving <= 1'b0;
      hdr_done  <= 1'b0;
      byte_cnt  <= '0;
    end else begin
      if (start) receiving <= 1'b1;
      if (in_frm && ip_strm.eof) receiving <= 1'b0;
      byte_cnt <= cnt_nxt;
      if (take && byte_cnt == UDP_HDR_LEN - 16'd1) hdr_done <= 1'b1;
    end
  end

  // One clear cycle after each frame
  always_ff @(posedge clk) begin
    if (fsm_rst) frm_clr <= 1'b0;
    else frm_clr <= in_frm && ip_strm.eof;
  end

  always_ff @(posedge clk) begin
    if (take) hdr <= hdr_full;
  end

  always_ff @(posedge clk) begin
    if (start) udp_meta.ipv4_hdr <= ip_meta.ipv4_hdr;
    if (take && byte_cnt == UDP_HDR_LEN - 16'd1) begin
      udp_meta.udp_hdr.src_port <= hdr_full[7:6];
      udp_meta.udp_hdr.dst_port <= hdr_full[5:4];
      udp_meta.udp_hdr.length   <= hdr_full[3:2];
      udp_meta.udp_hdr.cks      <= hdr_full[1:0];
    end
  end

  always_ff @(posedge clk) begin
    udp_strm.dat <= ip_strm.dat;
    if (fsm_rst) begin
      udp_strm.val <= 1'b0;
      udp_strm.sof <= 1'b0;
      udp_strm.eof <= 1'b0;
      udp_strm.err <= 1'b0;
    end else begin
      udp_strm.val <= take && hdr_done;
      udp_strm.sof <= take && byte_cnt == UDP_HDR_LEN; // First byte after header
      udp_strm.eof <= in_frm && hdr_done && ip_strm.eof;
      udp_strm.err <= in_frm && hdr_done && ip_strm.eof && (ip_strm.err || len_err);
    end
  end

endmodule

`default_nettype wire

//--- verilog/udp_port_filter.sv
`timescale 1ns/100ps
`default_nettype none

module udp_port_filter
  import udp_rx_pkg::*;
(
  input  logic      clk,
  input  logic      fsm_rst,
  input  dev_t      dev,
  input  strm_t     udp_strm,
  input  udp_meta_t udp_meta,
  output strm_t     pld,
  output udp_meta_t meta,
  output cnt_t      rx_count,
  output cnt_t      drop_count,
  output cnt_t      err_count
);

  logic active;
  logic pass;
  logic match;
  logic in_frm;
  logic pass_now;
  logic frm_end;
  logic end_ok;
  logic end_err;
  logic end_drop;

  function automatic cnt_t sat_inc(input cnt_t c);
    return (c == '1) ? c : c + 16'd1;
  endfunction

  assign match    = udp_meta.udp_hdr.dst_port == dev.udp_port;
  assign in_frm   = active || udp_strm.sof;
  assign pass_now = udp_strm.sof ? match : pass; // Decision held for the frame
  assign frm_end  = in_frm && udp_strm.eof;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      active <= 1'b0;
      pass   <= 1'b0;
    end else begin
      if (udp_strm.sof) begin
        active <= 1'b1;
        pass   <= match;
      end
      if (frm_end) active <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    pld.dat <= udp_strm.dat;
    if (fsm_rst) begin
      pld.val <= 1'b0;
      pld.sof <= 1'b0;
      pld.eof <= 1'b0;
      pld.err <= 1'b0;
    end else begin
      pld.val <= udp_strm.val && in_frm && pass_now;
      pld.sof <= udp_strm.sof && match;
      pld.eof <= frm_end && pass_now;
      pld.err <= frm_end && pass_now && udp_strm.err;
    end
  end

  always_ff @(posedge clk) begin
    if (udp_strm.sof && match) meta <= udp_meta;
  end

  // Counted one cycle after the output eof
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      end_ok     <= 1'b0;
      end_err    <= 1'b0;
      end_drop   <= 1'b0;
      rx_count   <= '0;
      drop_count <= '0;
      err_count  <= '0;
    end else begin
      end_ok   <= frm_end && pass_now && !udp_strm.err;
      end_err  <= frm_end && pass_now && udp_strm.err;
      end_drop <= frm_end && !pass_now;
      if (end_ok) rx_count <= sat_inc(rx_count);
      if (end_drop) drop_count <= sat_inc(drop_count);
      if (end_err) err_count <= sat_inc(err_count);
    end
  end

endmodule

`default_nettype wire

//--- verilog/udp_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

module udp_rx_top
  import udp_rx_pkg::*;
(
  input  logic      clk,
  input  logic      fsm_rst,
  input  dev_t      dev,
  input  strm_t     rx,
  output strm_t     pld,
  output udp_meta_t meta,
  output cnt_t      rx_count,
  output cnt_t      drop_count,
  output cnt_t      err_count
);

  strm_t      ip_strm;
  ipv4_meta_t ip_meta;
  strm_t      udp_strm;
  udp_meta_t  udp_meta;

  // IPv4 header check and strip
  ipv4_rx ipv4_rx0 (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .dev     (dev),
    .rx      (rx),
    .ip_strm (ip_strm),
    .ip_meta (ip_meta)
  );

  udp_rx udp_rx0 (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .ip_strm  (ip_strm),
    .ip_meta  (ip_meta),
    .udp_strm (udp_strm),
    .udp_meta (udp_meta)
  );

  udp_port_filter udp_port_filter0 (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .dev        (dev),
    .udp_strm   (udp_strm),
    .udp_meta   (udp_meta),
    .pld        (pld),
    .meta       (meta),
    .rx_count   (rx_count),
    .drop_count (drop_count),
    .err_count  (err_count)
  );

endmodule

`default_nettype wire

//--- test/udp_rx_props.sv
`timescale 1ns/100ps
`default_nettype none

module udp_rx_props
  import udp_rx_pkg::*;
(
  input logic  clk,
  input logic  fsm_rst,
  input strm_t pld
);

  logic open_frm; // Between sof and eof

  always_ff @(posedge clk) begin
    if (fsm_rst) open_frm <= 1'b0;
    else if (pld.eof) open_frm <= 1'b0;
    else if (pld.sof) open_frm <= 1'b1;
  end

  err_with_eof: assert property (@(posedge clk) disable iff (fsm_rst) pld.err |-> pld.eof)
    else $error("pld.err raised without pld.eof");

  sof_with_val: assert property (@(posedge clk) disable iff (fsm_rst) pld.sof |-> pld.val)
    else $error("pld.sof raised without pld.val");

  single_sof: assert property (@(posedge clk) disable iff (fsm_rst) open_frm |-> !pld.sof)
    else $error("second pld.sof before pld.eof");

  // Outputs settle one edge into reset
  quiet_in_reset: assert property (@(posedge clk)
    fsm_rst && $past(fsm_rst) |-> !(pld.val || pld.sof || pld.eof || pld.err))
    else $error("pld strobes active during reset");

endmodule

bind udp_rx_top udp_rx_props props0 (
  .clk     (clk),
  .fsm_rst (fsm_rst),
  .pld     (pld)
);

`default_nettype wire

//--- test/tb_udp_rx.sv
`timescale 1ns/100ps
`default_nettype none

module tb_udp_rx
  import udp_rx_pkg::*;
();

  localparam int N_GOOD = 8;
  localparam int HDRS = int'(IPV4_HDR_LEN) + int'(UDP_HDR_LEN);

  typedef struct packed {
    int    cyc; // Cycle the byte must show at pld
    byte_t dat;
    logic  sof;
    logic  eof;
    logic  err;
  } exp_t;

  typedef struct packed {
    len_t       plen;
    byte_t      trunc;   // Payload bytes cut off the end
    len_t       len_adj; // Added to the UDP length field
    byte_t      proto;
    logic [3:0] ihl;
    ipv4_addr_t dst_ip;
    udp_port_t  dst_port;
    logic       bad_cks;
    logic       in_err;
    logic       gaps;
  } opt_t;

  logic      clk;
  logic      fsm_rst;
  dev_t      dev;
  strm_t     rx;
  strm_t     pld;
  udp_meta_t meta;
  cnt_t      rx_count;
  cnt_t      drop_count;
  cnt_t      err_count;
  cnt_t      exp_rx = '0;
  cnt_t      exp_drop = '0;
  cnt_t      exp_errc = '0;
  int        cyc = 0;
  int        seed = 32'h40f64d11;
  int        errors = 0;
  int        checks = 0;
  int        test_errs = 0;
  int        wd_cycles = 0;
  int        lens [N_GOOD];
  exp_t      exp_q [$];
  udp_meta_t meta_q [$];
  byte_t     frm [$];

  udp_rx_top dut0 (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .dev        (dev),
    .rx         (rx),
    .pld        (pld),
    .meta       (meta),
    .rx_count   (rx_count),
    .drop_count (drop_count),
    .err_count  (err_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  function automatic int rnd(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % $unsigned(hi - lo + 1));
  endfunction

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_meta(input udp_meta_t got, input udp_meta_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail meta: got %h, expected %h", got, exp);
    end
  endtask

  task automatic check_cnt(input string name, input cnt_t got, input cnt_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Ones-complement sum of the ten header words, folded twice
  function automatic logic [15:0] ip_checksum(input logic [159:0] h);
    logic [31:0] sum;
    sum = 32'd0;
    for (int i = 0; i < 10; i++) sum = sum + {16'd0, h[159 - 16 * i -: 16]};
    sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    return ~sum[15:0];
  endfunction

  function automatic opt_t good_opt(input len_t plen);
    opt_t o;
    o = '0;
    o.plen     = plen;
    o.proto    = PROTO_UDP;
    o.ihl      = IPV4_IHL;
    o.dst_ip   = dev.ipv4_addr;
    o.dst_port = dev.udp_port;
    o.gaps     = 1'b1;
    return o;
  endfunction

  task automatic send_frame(input opt_t o);
    logic [159:0] hdr;
    logic [223:0] hdrs;
    len_t         tot;
    len_t         ulen;
    ipv4_addr_t   src_ip;
    udp_port_t    src_port;
    logic [15:0]  id;
    byte_t        ttl;
    logic         rejected;
    logic         fwd;
    logic         bad;
    int           nbytes;
    int           last;
    udp_meta_t    m;
    exp_t         e;
    src_ip   = $random(seed);
    src_port = 16'($random(seed));
    id       = 16'($random(seed));
    ttl      = 8'($random(seed));
    tot      = IPV4_HDR_LEN + UDP_HDR_LEN + o.plen;
    ulen     = UDP_HDR_LEN + o.plen + o.len_adj;
    hdr = {IPV4_VERSION, o.ihl, 8'h00, tot, id, 16'h4000, ttl, o.proto, 16'h0000,
           src_ip, o.dst_ip};
    hdr[79:64] = ip_checksum(hdr) ^ {15'd0, o.bad_cks};
    hdrs = {hdr, src_port, o.dst_port, ulen, 16'h0000};
    nbytes = HDRS + int'(o.plen) - int'(o.trunc);
    frm.delete();
    for (int i = 0; i < HDRS; i++) frm.push_back(hdrs[223 - 8 * i -: 8]);
    for (int i = HDRS; i < nbytes; i++) frm.push_back(8'($random(seed)));
    rejected = o.ihl != IPV4_IHL || o.bad_cks || o.dst_ip != dev.ipv4_addr ||
               o.proto != PROTO_UDP;
    fwd = !rejected && o.dst_port == dev.udp_port;
    bad = o.trunc != 8'd0 || o.len_adj != 16'd0 || o.in_err;
    m.ipv4_hdr.proto     = o.proto;
    m.ipv4_hdr.total_len = tot;
    m.ipv4_hdr.src_ip    = src_ip;
    m.ipv4_hdr.dst_ip    = o.dst_ip;
    m.ipv4_hdr.id        = id;
    m.ipv4_hdr.ttl       = ttl;
    m.udp_hdr.src_port   = src_port;
    m.udp_hdr.dst_port   = o.dst_port;
    m.udp_hdr.length     = ulen;
    m.udp_hdr.cks        = 16'h0000;
    if (fwd) meta_q.push_back(m);
    last = nbytes - 1;
    for (int i = 0; i <= last; i++) begin
      if (o.gaps && i > 0 && rnd(0, 3) == 0) begin
        @(posedge clk);
        #2 rx = '0;
      end
      @(posedge clk);
      #2;
      rx.dat = frm[i];
      rx.val = 1'b1;
      rx.sof = (i == 0);
      rx.eof = (i == last);
      rx.err = o.in_err && (i == last);
      if (fwd && i >= HDRS) begin
        e.cyc = cyc + 3; // Fixed pipeline latency
        e.dat = frm[i];
        e.sof = (i == HDRS);
        e.eof = (i == last);
        e.err = bad && (i == last);
        exp_q.push_back(e);
      end
    end
    repeat (2) begin
      @(posedge clk);
      #2 rx = '0;
    end
    if (!rejected && !fwd) exp_drop++;
    else if (fwd && bad) exp_errc++;
    else if (fwd) exp_rx++;
  endtask

  always @(negedge clk) begin
    exp_t e;
    if (!fsm_rst && (pld.val || pld.sof || pld.eof)) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected output byte %h at cycle %0d", pld.dat, cyc);
      end else begin
        e = exp_q.pop_front();
        if (e.cyc != cyc) begin
          errors++;
          $display("Byte %h came out at cycle %0d instead of %0d", pld.dat, cyc, e.cyc);
        end
        check_flag("pld.val", pld.val, 1'b1);
        check_byte("pld.dat", pld.dat, e.dat);
        check_flag("pld.sof", pld.sof, e.sof);
        check_flag("pld.eof", pld.eof, e.eof);
        check_flag("pld.err", pld.err, e.err);
      end
      if (pld.sof && meta_q.size() != 0) check_meta(meta, meta_q.pop_front());
    end
  end

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 40) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0 || meta_q.size() != 0) begin
      errors++;
      $display("%0d expected payload bytes never came out", exp_q.size());
      exp_q.delete();
      meta_q.delete();
    end
    repeat (4) @(negedge clk); // Counters trail the output eof
    check_cnt("rx_count", rx_count, exp_rx);
    check_cnt("drop_count", drop_count, exp_drop);
    check_cnt("err_count", err_count, exp_errc);
  endtask

  task automatic report_test(input string name);
    $display("%-16s %s (%0d errors)", name, errors == test_errs ? "ok" : "FAILED",
             errors - test_errs);
    test_errs = errors;
  endtask

  task automatic reset_and_idle();
    repeat (10) begin
      @(negedge clk);
      check_flag("pld.val", pld.val, 1'b0);
      check_flag("pld.sof", pld.sof, 1'b0);
      check_flag("pld.eof", pld.eof, 1'b0);
      check_flag("pld.err", pld.err, 1'b0);
    end
    check_cnt("rx_count", rx_count, '0);
    check_cnt("drop_count", drop_count, '0);
    check_cnt("err_count", err_count, '0);
    report_test("reset and idle");
  endtask

  task automatic good_datagrams();
    for (int i = 0; i < N_GOOD; i++) send_frame(good_opt(len_t'(lens[i])));
    wait_drain();
    report_test("good datagrams");
  endtask

  task automatic port_mismatch();
    opt_t o;
    o = good_opt(16'd16);
    o.dst_port = dev.udp_port ^ 16'h0101;
    send_frame(o);
    wait_drain();
    report_test("port mismatch");
  endtask

  task automatic rejected_frames();
    opt_t o;
    o = good_opt(16'd12);
    o.bad_cks = 1'b1;
    send_frame(o);
    o = good_opt(16'd12);
    o.dst_ip = dev.ipv4_addr ^ 32'h0000_00ff;
    send_frame(o);
    o = good_opt(16'd12);
    o.proto = 8'd6; // TCP
    send_frame(o);
    o = good_opt(16'd12);
    o.ihl = 4'd6;
    send_frame(o);
    send_frame(good_opt(16'd12));
    wait_drain();
    report_test("rejected frames");
  endtask

  task automatic length_errors();
    opt_t o;
    o = good_opt(16'd20);
    o.trunc = 8'd5;
    send_frame(o);
    o = good_opt(16'd20);
    o.len_adj = 16'd3;
    send_frame(o);
    o = good_opt(16'd20);
    o.in_err = 1'b1;
    send_frame(o);
    wait_drain();
    report_test("length errors");
  endtask

  initial begin
    fsm_rst = 1'b1;
    rx = '0;
    dev.ipv4_addr = 32'hc0a8_0a02;
    dev.udp_port  = 16'd5005;
    for (int i = 0; i < N_GOOD; i++) lens[i] = rnd(1, 64);
    for (int i = 0; i < N_GOOD; i++) wd_cycles += HDRS + lens[i];
    wd_cycles += (HDRS + 16) + 5 * (HDRS + 12) + 3 * (HDRS + 20);
    wd_cycles = wd_cycles * 3 + 200;
    repeat (8) @(posedge clk);
    #2 fsm_rst = 1'b0;
    reset_and_idle();
    good_datagrams();
    port_mismatch();
    rejected_frames();
    length_errors();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", wd_cycles);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
verilog/udp_rx_pkg.sv
verilog/ipv4_rx.sv
verilog/udp_rx.sv
verilog/udp_port_filter.sv
verilog/udp_rx_top.sv
test/udp_rx_props.sv
test/tb_udp_rx.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_udp_rx
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
